// File: Bender.yml
package:
  name: mem_wb

sources:
  # Packages first
  - common/instrPkg.sv
  - common/memPkg.sv
  # Memory stage
  - memStage/byteEnable.sv
  - memStage/dataMemory.sv
  - memStage/memStage.sv
  # Writeback side and top level
  - source/loadAlign.sv
  - source/memWbTop.sv
  # Testbench
  - target: test
    files:
      - tests/clockGen.sv
      - tests/memWbAsserts.sv
      - tests/memWbTb.sv

// File: common/instrPkg.sv
package instrPkg;

	////////////////////////////////////////
	// Memory operation classes
	////////////////////////////////////////

	// Only memory instructions matter in this stage
	// Everything else collapses into opNone
	typedef enum logic [3:0]
	{
		opNone = 4'd0,
		opLw   = 4'd1,
		opLh   = 4'd2,
		opLhu  = 4'd3,
		opLb   = 4'd4,
		opLbu  = 4'd5,
		opSw   = 4'd6,
		opSh   = 4'd7,
		opSb   = 4'd8
	} memOpT;

	////////////////////////////////////////
	// Hazard timing
	////////////////////////////////////////

	// Tuse or Tnew count in cycles
	typedef logic [2:0] hazCntT;

	// Register never read by this instruction
	localparam hazCntT tuseNever = 3'b111;

	// Register number, 32 GPRs
	typedef logic [4:0] regAddrT;

endpackage

// File: common/memPkg.sv
package memPkg;

	////////////////////////////////////////
	// Data word views
	////////////////////////////////////////

	// Same word as four bytes or two halfwords
	// Index 0 is the least significant lane
	typedef union packed
	{
		logic [3:0][7:0]  bytes;
		logic [1:0][15:0] halves;
	} dataWordU;

	////////////////////////////////////////
	// Load extension
	////////////////////////////////////////

	// extNone passes the full word (lw)
	typedef enum logic [2:0]
	{
		extNone       = 3'd0,
		extByteSigned = 3'd1,
		extByteZero   = 3'd2,
		extHalfSigned = 3'd3,
		extHalfZero   = 3'd4
	} extOpT;

	// Store data source
	// wdFromWb picks up the writeback forward
	typedef enum logic
	{
		wdFromEx = 1'b0,
		wdFromWb = 1'b1
	} wdSelT;

endpackage

// File: compile.f
common/instrPkg.sv
common/memPkg.sv
memStage/byteEnable.sv
memStage/dataMemory.sv
memStage/memStage.sv
source/loadAlign.sv
source/memWbTop.sv
tests/clockGen.sv
tests/memWbAsserts.sv
tests/memWbTb.sv

// File: memStage/byteEnable.sv
`timescale 1ns/1ps

module byteEnable
	import instrPkg::*;
(
	input  memOpT      memOp,
	input  logic [1:0] addrLow,
	output logic [3:0] byteEn
);

	////////////////////////////////////////
	// Store lane selection
	////////////////////////////////////////

	// Bit i enables byte lane i of the word
	always_comb
	begin
		case (memOp)
			// Whole word, offset ignored
			opSw:
				byteEn = 4'b1111;
			// Halfword by address bit 1, bit 0 ignored
			opSh:
				byteEn = addrLow[1] ? 4'b1100 : 4'b0011;
			// Single byte at the offset
			opSb:
				byteEn = 4'b0001 << addrLow;
			// Loads and bubbles leave memory alone
			default:
				byteEn = 4'b0000;
		endcase
	end

endmodule

// File: memStage/dataMemory.sv
`timescale 1ns/1ps

module dataMemory
	import memPkg::*;
#(
	parameter int memWords = 1024
)
(
	input  logic        clk,
	input  logic        reset,
	input  logic [31:0] addr,
	input  logic [31:0] writeData,
	input  logic [3:0]  byteEn,
	output logic [31:0] readData
);

	// Power-of-two depth, so slicing wraps the index
	localparam int idxBits = $clog2(memWords);

	dataWordU               memArr [memWords];
	dataWordU               wordIn;
	dataWordU               merged;
	logic [idxBits-1:0]     wordIdx;

	// Byte offset sits below the word index
	assign wordIdx = addr[idxBits+1:2];
	assign wordIn  = writeData;

	// Async read of the addressed word
	assign readData = memArr[wordIdx];

	////////////////////////////////////////
	// Write merge
	////////////////////////////////////////

	// Low part of the store data lands in the addressed lane
	always_comb
	begin
		merged = memArr[wordIdx];
		case (byteEn)
			4'b1111: merged = wordIn;
			4'b0011: merged.halves[0] = wordIn.halves[0];
			4'b1100: merged.halves[1] = wordIn.halves[0];
			4'b0001, 4'b0010, 4'b0100, 4'b1000:
				merged.bytes[addr[1:0]] = wordIn.bytes[0];
			default: ;
		endcase
	end

	// Whole array cleared on reset
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < memWords; i++)
				memArr[i] <= '0;
		end
		else if (|byteEn)
		begin
			memArr[wordIdx] <= merged;
		end
	end

endmodule

// File: memStage/memStage.sv
`timescale 1ns/1ps

module memStage
	import instrPkg::*;
	import memPkg::*;
#(
	parameter int          memWords = 1024,
	parameter logic [31:0] resetPc  = 32'h0000_3000
)
(
	input  logic        clk,
	input  logic        reset,
	input  memOpT       memOp,
	input  logic [31:0] aluOut,
	input  logic [31:0] exWriteData,
	input  logic [31:0] wbBypass,
	input  wdSelT       writeDataSel,
	input  logic [31:0] pc,
	input  regAddrT     regWriteAddr,
	input  regAddrT     readAddr0,
	input  regAddrT     readAddr1,
	input  hazCntT      tuse0,
	input  hazCntT      tuse1,
	input  hazCntT      tnew,
	output regAddrT     hazReadAddr0,
	output regAddrT     hazReadAddr1,
	output regAddrT     hazWriteAddr,
	output hazCntT      hazTuse0,
	output hazCntT      hazTuse1,
	output hazCntT      hazTnew,
	output logic [31:0] wbAluOut,
	output logic [31:0] wbReadData,
	output logic [31:0] wbPc,
	output regAddrT     wbRegAddr,
	output hazCntT      wbTuse0,
	output hazCntT      wbTuse1,
	output hazCntT      wbTnew,
	output extOpT       wbExtOp,
	output logic [1:0]  wbByteSel,
	output logic        wbLoad
);

	logic [31:0] storeData;
	logic [31:0] readData;
	logic [3:0]  byteEn;
	extOpT       extOp;
	logic        isLoad;

	// One cycle closer, stuck at zero once ready
	function automatic hazCntT decCnt(input hazCntT cnt);
		return (cnt != '0) ? hazCntT'(cnt - 3'd1) : cnt;
	endfunction

	////////////////////////////////////////
	// Hazard unit view
	////////////////////////////////////////

	// Register numbers go out as they came in
	assign hazReadAddr0 = readAddr0;
	assign hazReadAddr1 = readAddr1;
	assign hazWriteAddr = regWriteAddr;
	assign hazTuse0     = decCnt(tuse0);
	assign hazTuse1     = decCnt(tuse1);
	assign hazTnew      = decCnt(tnew);

	////////////////////////////////////////
	// Data memory access
	////////////////////////////////////////

	// Forwarded value wins for back-to-back dependent stores
	assign storeData = (writeDataSel == wdFromWb) ? wbBypass : exWriteData;

	byteEnable u_byteEnable
	(
		.memOp   (memOp),
		.addrLow (aluOut[1:0]),
		.byteEn  (byteEn)
	);

	dataMemory #(
		.memWords (memWords)
	) u_dataMemory
	(
		.clk       (clk),
		.reset     (reset),
		.addr      (aluOut),
		.writeData (storeData),
		.byteEn    (byteEn),
		.readData  (readData)
	);

	// Load kind for the writeback aligner
	always_comb
	begin
		extOp  = extNone;
		isLoad = 1'b1;
		case (memOp)
			opLw:    extOp = extNone;
			opLh:    extOp = extHalfSigned;
			opLhu:   extOp = extHalfZero;
			opLb:    extOp = extByteSigned;
			opLbu:   extOp = extByteZero;
			default: isLoad = 1'b0;
		endcase
	end

	////////////////////////////////////////
	// MEM/WB register
	////////////////////////////////////////

	// Control and bookkeeping fields
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wbPc      <= resetPc;
			wbRegAddr <= '0;
			wbTuse0   <= tuseNever;
			wbTuse1   <= tuseNever;
			wbTnew    <= '0;
			wbExtOp   <= extNone;
			wbLoad    <= 1'b0;
		end
		else
		begin
			wbPc      <= pc;
			wbRegAddr <= regWriteAddr;
			wbTuse0   <= hazTuse0;
			wbTuse1   <= hazTuse1;
			wbTnew    <= hazTnew;
			wbExtOp   <= extOp;
			wbLoad    <= isLoad;
		end
	end

	// Data payload
	always_ff @(posedge clk)
	begin
		wbAluOut   <= aluOut;
		wbReadData <= readData;
		// Offset inside the word, used by the aligner
		wbByteSel  <= aluOut[1:0];
	end

endmodule

// File: source/loadAlign.sv
`timescale 1ns/1ps

module loadAlign
	import memPkg::*;
(
	input  logic        wbLoad,
	input  extOpT       wbExtOp,
	input  logic [1:0]  wbByteSel,
	input  logic [31:0] wbReadData,
	input  logic [31:0] wbAluOut,
	output logic [31:0] wbResult
);

	dataWordU    rdWord;
	logic [7:0]  pickByte;
	logic [15:0] pickHalf;
	logic [31:0] aligned;

	assign rdWord = wbReadData;

	////////////////////////////////////////
	// Field selection
	////////////////////////////////////////

	// Byte by both offset bits, halfword by bit 1 only
	assign pickByte = rdWord.bytes[wbByteSel];
	assign pickHalf = rdWord.halves[wbByteSel[1]];

	// Sign or zero fill up to 32 bits
	always_comb
	begin
		case (wbExtOp)
			extByteSigned: aligned = {{24{pickByte[7]}}, pickByte};
			extByteZero:   aligned = {24'd0, pickByte};
			extHalfSigned: aligned = {{16{pickHalf[15]}}, pickHalf};
			extHalfZero:   aligned = {16'd0, pickHalf};
			// lw, full word
			default:       aligned = rdWord;
		endcase
	end

	////////////////////////////////////////
	// Result mux
	////////////////////////////////////////

	// Non-loads write back the ALU value
	assign wbResult = wbLoad ? aligned : wbAluOut;

endmodule

// File: source/memWbTop.sv
`timescale 1ns/1ps

module memWbTop
	import instrPkg::*;
	import memPkg::*;
#(
	parameter int          memWords = 1024,
	parameter logic [31:0] resetPc  = 32'h0000_3000
)
(
	input  logic        clk,
	input  logic        reset,
	input  memOpT       memOp,
	input  logic [31:0] aluOut,
	input  logic [31:0] exWriteData,
	input  logic [31:0] wbBypass,
	input  wdSelT       writeDataSel,
	input  logic [31:0] pc,
	input  regAddrT     regWriteAddr,
	input  regAddrT     readAddr0,
	input  regAddrT     readAddr1,
	input  hazCntT      tuse0,
	input  hazCntT      tuse1,
	input  hazCntT      tnew,
	output regAddrT     hazReadAddr0,
	output regAddrT     hazReadAddr1,
	output regAddrT     hazWriteAddr,
	output hazCntT      hazTuse0,
	output hazCntT      hazTuse1,
	output hazCntT      hazTnew,
	output logic [31:0] wbResult,
	output logic [31:0] wbPc,
	output regAddrT     wbRegAddr,
	output hazCntT      wbTuse0,
	output hazCntT      wbTuse1,
	output hazCntT      wbTnew,
	output logic        wbLoad
);

	// MEM/WB fields consumed only by the aligner
	logic [31:0] wbAluOut;
	logic [31:0] wbReadData;
	extOpT       wbExtOp;
	logic [1:0]  wbByteSel;

	memStage #(
		.memWords (memWords),
		.resetPc  (resetPc)
	) u_memStage
	(
		.clk          (clk),
		.reset        (reset),
		.memOp        (memOp),
		.aluOut       (aluOut),
		.exWriteData  (exWriteData),
		.wbBypass     (wbBypass),
		.writeDataSel (writeDataSel),
		.pc           (pc),
		.regWriteAddr (regWriteAddr),
		.readAddr0    (readAddr0),
		.readAddr1    (readAddr1),
		.tuse0        (tuse0),
		.tuse1        (tuse1),
		.tnew         (tnew),
		.hazReadAddr0 (hazReadAddr0),
		.hazReadAddr1 (hazReadAddr1),
		.hazWriteAddr (hazWriteAddr),
		.hazTuse0     (hazTuse0),
		.hazTuse1     (hazTuse1),
		.hazTnew      (hazTnew),
		.wbAluOut     (wbAluOut),
		.wbReadData   (wbReadData),
		.wbPc         (wbPc),
		.wbRegAddr    (wbRegAddr),
		.wbTuse0      (wbTuse0),
		.wbTuse1      (wbTuse1),
		.wbTnew       (wbTnew),
		.wbExtOp      (wbExtOp),
		.wbByteSel    (wbByteSel),
		.wbLoad       (wbLoad)
	);

	// Writeback side, purely combinational
	loadAlign u_loadAlign
	(
		.wbLoad     (wbLoad),
		.wbExtOp    (wbExtOp),
		.wbByteSel  (wbByteSel),
		.wbReadData (wbReadData),
		.wbAluOut   (wbAluOut),
		.wbResult   (wbResult)
	);

endmodule

// File: tests/clockGen.sv
`timescale 1ns/1ps

module clockGen
#(
	parameter int periodNs    = 40,
	parameter int resetCycles = 3
)
(
	output logic clk,
	output logic reset
);

	// Free-running clock, low at time zero
	initial
	begin
		clk = 1'b0;
		forever #(periodNs / 2) clk = ~clk;
	end

	// Reset high for the first few rising edges
	initial
	begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

// File: tests/memWbAsserts.sv
`timescale 1ns/1ps

module memWbAsserts
	import instrPkg::*;
(
	input logic   clk,
	input logic   reset,
	input memOpT  memOp,
	input hazCntT tuse0,
	input hazCntT tuse1,
	input hazCntT tnew,
	input hazCntT hazTuse0,
	input hazCntT hazTuse1,
	input hazCntT hazTnew,
	input logic   wbLoad,
	input hazCntT wbTnew
);

	// Failure tally, watched by the testbench
	int   failCount = 0;
	logic loadOp;

	assign loadOp = (memOp == opLw) || (memOp == opLh) || (memOp == opLhu)
		|| (memOp == opLb) || (memOp == opLbu);

	////////////////////////////////////////
	// Reset values
	////////////////////////////////////////

	// First edge out of reset still shows the cleared register
	resetClear: assert property (@(posedge clk)
		$fell(reset) |-> (!wbLoad && wbTnew == 3'd0))
	else
	begin
		failCount++;
		$error("wbLoad or wbTnew not cleared after reset");
	end

	////////////////////////////////////////
	// Counter rules
	////////////////////////////////////////

	// Minus one, floor at zero
	tuse0Dec: assert property (@(posedge clk) disable iff (reset)
		hazTuse0 == ((tuse0 == 3'd0) ? 3'd0 : tuse0 - 3'd1))
	else
	begin
		failCount++;
		$error("hazTuse0 breaks the decrement rule");
	end

	tuse1Dec: assert property (@(posedge clk) disable iff (reset)
		hazTuse1 == ((tuse1 == 3'd0) ? 3'd0 : tuse1 - 3'd1))
	else
	begin
		failCount++;
		$error("hazTuse1 breaks the decrement rule");
	end

	tnewDec: assert property (@(posedge clk) disable iff (reset)
		hazTnew == ((tnew == 3'd0) ? 3'd0 : tnew - 3'd1))
	else
	begin
		failCount++;
		$error("hazTnew breaks the decrement rule");
	end

	// Load flag trails the opcode by one cycle
	loadFlag: assert property (@(posedge clk) disable iff (reset)
		wbLoad == $past(loadOp))
	else
	begin
		failCount++;
		$error("wbLoad does not follow the previous opcode");
	end

endmodule

// File: tests/memWbTb.sv
`timescale 1ns/1ps

module memWbTb
	import instrPkg::*;
	import memPkg::*;
();

	localparam int          tbWords   = 64;
	localparam logic [31:0] tbResetPc = 32'h0000_3000;

	// Test section lengths
	localparam int resetLoads  = 4;
	localparam int storeTests  = 40;
	localparam int extWords    = 8;
	localparam int bypassTests = 10;
	localparam int passTests   = 20;
	localparam int hazTests    = 30;

	// Reset, every section, the drain at the end
	localparam int plannedCycles = 3 + resetLoads + 2 * storeTests + extWords * 17
		+ 2 * bypassTests + passTests + 4 + hazTests + 3;
	localparam int cycleLimit = 2 * plannedCycles + 20;

	localparam memOpT storeOps [3] = '{opSw, opSh, opSb};
	localparam memOpT extOps [4]   = '{opLb, opLbu, opLh, opLhu};

	// Expected MEM/WB view of one instruction
	typedef struct packed
	{
		logic [31:0] result;
		logic [31:0] pc;
		regAddrT     regAddr;
		hazCntT      tuse0;
		hazCntT      tuse1;
		hazCntT      tnew;
		logic        load;
	} expT;

	logic        clk;
	logic        reset;
	memOpT       memOp;
	logic [31:0] aluOut;
	logic [31:0] exWriteData;
	logic [31:0] wbBypass;
	wdSelT       writeDataSel;
	logic [31:0] pc;
	regAddrT     regWriteAddr;
	regAddrT     readAddr0;
	regAddrT     readAddr1;
	hazCntT      tuse0;
	hazCntT      tuse1;
	hazCntT      tnew;
	regAddrT     hazReadAddr0;
	regAddrT     hazReadAddr1;
	regAddrT     hazWriteAddr;
	hazCntT      hazTuse0;
	hazCntT      hazTuse1;
	hazCntT      hazTnew;
	logic [31:0] wbResult;
	logic [31:0] wbPc;
	regAddrT     wbRegAddr;
	hazCntT      wbTuse0;
	hazCntT      wbTuse1;
	hazCntT      wbTnew;
	logic        wbLoad;

	int          seed = 32'h68d6_afaa;
	logic [31:0] refMem [tbWords];
	expT         expQ [$];
	expT         pend;
	bit          pendValid = 1'b0;
	bit          started = 1'b0;
	int          issuedCount = 0;
	int          checkedCount = 0;
	int          cycleCount = 0;

	clockGen #(
		.periodNs    (40),
		.resetCycles (3)
	) u_clockGen
	(
		.clk   (clk),
		.reset (reset)
	);

	memWbTop #(
		.memWords (tbWords),
		.resetPc  (tbResetPc)
	) u_memWbTop
	(
		.clk          (clk),
		.reset        (reset),
		.memOp        (memOp),
		.aluOut       (aluOut),
		.exWriteData  (exWriteData),
		.wbBypass     (wbBypass),
		.writeDataSel (writeDataSel),
		.pc           (pc),
		.regWriteAddr (regWriteAddr),
		.readAddr0    (readAddr0),
		.readAddr1    (readAddr1),
		.tuse0        (tuse0),
		.tuse1        (tuse1),
		.tnew         (tnew),
		.hazReadAddr0 (hazReadAddr0),
		.hazReadAddr1 (hazReadAddr1),
		.hazWriteAddr (hazWriteAddr),
		.hazTuse0     (hazTuse0),
		.hazTuse1     (hazTuse1),
		.hazTnew      (hazTnew),
		.wbResult     (wbResult),
		.wbPc         (wbPc),
		.wbRegAddr    (wbRegAddr),
		.wbTuse0      (wbTuse0),
		.wbTuse1      (wbTuse1),
		.wbTnew       (wbTnew),
		.wbLoad       (wbLoad)
	);

	// Counter checks sit inside the stage
	bind memStage memWbAsserts u_memWbAsserts
	(
		.clk      (clk),
		.reset    (reset),
		.memOp    (memOp),
		.tuse0    (tuse0),
		.tuse1    (tuse1),
		.tnew     (tnew),
		.hazTuse0 (hazTuse0),
		.hazTuse1 (hazTuse1),
		.hazTnew  (hazTnew),
		.wbLoad   (wbLoad),
		.wbTnew   (wbTnew)
	);

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	// One cycle closer, floor at zero
	function automatic hazCntT expectedCount(input hazCntT cnt);
		if (cnt == 3'd0)
			return 3'd0;
		return cnt - 3'd1;
	endfunction

	// Zero in about a quarter of the draws
	function automatic hazCntT randCount();
		if (($random(seed) & 3) == 0)
			return 3'd0;
		return hazCntT'($random(seed));
	endfunction

	// Writeback value and bookkeeping for one instruction
	function automatic expT refModel(input memOpT op, input logic [31:0] addr,
		input logic [31:0] pcIn, input regAddrT rd, input hazCntT t0, input hazCntT t1,
		input hazCntT tn);
		expT         e;
		logic [31:0] word;
		logic [7:0]  b;
		logic [15:0] h;
		word = refMem[(addr >> 2) % tbWords];
		b    = word[8 * addr[1:0] +: 8];
		// Bit 0 ignored for halfwords
		h    = word[16 * addr[1] +: 16];
		e.load = 1'b1;
		case (op)
			opLw:  e.result = word;
			opLb:  e.result = {{24{b[7]}}, b};
			opLbu: e.result = {24'd0, b};
			opLh:  e.result = {{16{h[15]}}, h};
			opLhu: e.result = {16'd0, h};
			default:
			begin
				e.result = addr;
				e.load   = 1'b0;
			end
		endcase
		e.pc      = pcIn;
		e.regAddr = rd;
		e.tuse0   = expectedCount(t0);
		e.tuse1   = expectedCount(t1);
		e.tnew    = expectedCount(tn);
		return e;
	endfunction

	// Low bits of the data land in the addressed lane
	function automatic void refStore(input memOpT op, input logic [31:0] addr,
		input logic [31:0] data);
		int idx;
		idx = (addr >> 2) % tbWords;
		case (op)
			opSw: refMem[idx] = data;
			opSh: refMem[idx][16 * addr[1] +: 16] = data[15:0];
			opSb: refMem[idx][8 * addr[1:0] +: 8] = data[7:0];
			default: ;
		endcase
	endfunction

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
			$display("Finished with errors");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	// One instruction per rising edge, random bookkeeping fields
	task automatic driveInstr(input memOpT op, input logic [31:0] addr,
		input logic [31:0] exData, input logic [31:0] bypass, input wdSelT sel);
		hazCntT      t0;
		hazCntT      t1;
		hazCntT      tn;
		regAddrT     rd;
		logic [31:0] pcVal;
		t0    = randCount();
		t1    = randCount();
		tn    = randCount();
		rd    = regAddrT'($random(seed));
		pcVal = $random(seed) & 32'hffff_fffc;
		@(posedge clk);
		memOp        <= op;
		aluOut       <= addr;
		exWriteData  <= exData;
		wbBypass     <= bypass;
		writeDataSel <= sel;
		pc           <= pcVal;
		regWriteAddr <= rd;
		readAddr0    <= regAddrT'($random(seed));
		readAddr1    <= regAddrT'($random(seed));
		tuse0        <= t0;
		tuse1        <= t1;
		tnew         <= tn;
		// Expectation sees memory before this store
		expQ.push_back(refModel(op, addr, pcVal, rd, t0, t1, tn));
		refStore(op, addr, (sel == wdFromWb) ? bypass : exData);
		issuedCount++;
	endtask

	initial
	begin
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] passAddr [4];
		for (int i = 0; i < tbWords; i++)
			refMem[i] = '0;
		memOp        = opNone;
		aluOut       = '0;
		exWriteData  = '0;
		wbBypass     = '0;
		writeDataSel = wdFromEx;
		pc           = '0;
		regWriteAddr = '0;
		readAddr0    = '0;
		readAddr1    = '0;
		tuse0        = '0;
		tuse1        = '0;
		tnew         = '0;

		// Register still holds its reset values
		wait (reset === 1'b1);
		wait (reset === 1'b0);
		@(negedge clk);
		checkValue("wbLoad", wbLoad, 1'b0);
		checkValue("wbTnew", wbTnew, 3'd0);
		checkValue("wbTuse0", wbTuse0, tuseNever);
		checkValue("wbTuse1", wbTuse1, tuseNever);
		checkValue("wbPc", wbPc, tbResetPc);
		checkValue("wbRegAddr", wbRegAddr, 5'd0);
		started = 1'b1;

		// Cleared memory reads zero
		for (int i = 0; i < resetLoads; i++)
			driveInstr(opLw, $random(seed), 32'd0, 32'd0, wdFromEx);

		// Each store read back as a whole word
		for (int i = 0; i < storeTests; i++)
		begin
			addr = $random(seed);
			data = $random(seed);
			driveInstr(storeOps[$unsigned($random(seed)) % 3], addr, data, ~data, wdFromEx);
			driveInstr(opLw, addr, 32'd0, 32'd0, wdFromEx);
		end

		// Every extension at every offset
		for (int w = 0; w < extWords; w++)
		begin
			addr = $random(seed) & ~32'h3;
			driveInstr(opSw, addr, $random(seed), 32'd0, wdFromEx);
			for (int k = 0; k < 4; k++)
				for (int off = 0; off < 4; off++)
					driveInstr(extOps[k], addr + off, 32'd0, 32'd0, wdFromEx);
		end

		// Forwarded value is the one stored
		for (int i = 0; i < bypassTests; i++)
		begin
			addr = $random(seed) & ~32'h3;
			data = $random(seed);
			driveInstr(opSw, addr, ~data, data, wdFromWb);
			driveInstr(opLw, addr, 32'd0, 32'd0, wdFromEx);
		end

		// ALU results pass through, memory untouched
		for (int i = 0; i < passTests; i++)
		begin
			addr = $random(seed);
			if (i < 4)
				passAddr[i] = addr;
			driveInstr(opNone, addr, $random(seed), $random(seed), wdSelT'(i & 1));
		end
		for (int i = 0; i < 4; i++)
			driveInstr(opLw, passAddr[i], 32'd0, 32'd0, wdFromEx);

		// More counter values, loads and bubbles mixed
		for (int i = 0; i < hazTests; i++)
			driveInstr((i % 2) ? opLw : opNone, $random(seed), 32'd0, 32'd0, wdFromEx);

		driveInstr(opNone, 32'd0, 32'd0, 32'd0, wdFromEx);
		wait (checkedCount == issuedCount);
		// Bound checks sample one edge later
		@(posedge clk);
		@(negedge clk);
		$display("Finished with no errors");
		$finish;
	end

	////////////////////////////////////////
	// Comparison
	////////////////////////////////////////

	// Mid-cycle, all outputs settled
	always @(negedge clk)
	begin
		if (started)
		begin
			// Hazard view of the instruction now at the inputs
			checkValue("hazReadAddr0", hazReadAddr0, readAddr0);
			checkValue("hazReadAddr1", hazReadAddr1, readAddr1);
			checkValue("hazWriteAddr", hazWriteAddr, regWriteAddr);
			checkValue("hazTuse0", hazTuse0, expectedCount(tuse0));
			checkValue("hazTuse1", hazTuse1, expectedCount(tuse1));
			checkValue("hazTnew", hazTnew, expectedCount(tnew));
			// Writeback view of the previous one
			if (pendValid)
			begin
				checkValue("wbResult", wbResult, pend.result);
				checkValue("wbLoad", wbLoad, pend.load);
				checkValue("wbPc", wbPc, pend.pc);
				checkValue("wbRegAddr", wbRegAddr, pend.regAddr);
				checkValue("wbTuse0", wbTuse0, pend.tuse0);
				checkValue("wbTuse1", wbTuse1, pend.tuse1);
				checkValue("wbTnew", wbTnew, pend.tnew);
				checkedCount++;
			end
			pendValid = (expQ.size() != 0);
			if (pendValid)
				pend = expQ.pop_front();
		end
	end

	// First bound assertion failure ends the run
	always @(u_memWbTop.u_memStage.u_memWbAsserts.failCount)
	begin
		if (u_memWbTop.u_memStage.u_memWbAsserts.failCount != 0)
		begin
			$display("A bound assertion failed in cycle %0d", cycleCount);
			$display("Finished with errors");
			$fatal(1, "Assertion failure");
		end
	end

	// Run length guard
	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount >= cycleLimit)
		begin
			$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("Finished with errors");
			$fatal(1, "Timeout");
		end
	end

endmodule
